// File: logic/udma_pkg.sv
/*
 * uDMA L2 channel shared definitions
 * Bus widths, register map and the positions of the config and status bits
 */
package udma_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////

    localparam int CFG_AW     = 5;   // cfg register address
    localparam int CFG_DW     = 32;  // cfg read and write data
    localparam int WORD_BYTES = 4;   // Stream word size

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////

    typedef enum logic [CFG_AW-1:0] {
        RX_SADDR = 5'd0,  // RX start address in L2
        RX_SIZE  = 5'd1,  // RX size, reads back bytes left
        RXCFG    = 5'd2,  // RX enable
        TX_SADDR = 5'd3,  // TX start address in L2
        TX_SIZE  = 5'd4,  // TX size, reads back bytes left
        TXCFG    = 5'd5,  // TX enable
        STATUS   = 5'd9   // Busy flags
    } cfg_reg_e;

    //////////////////////////////////////////////////
    // Field positions
    //////////////////////////////////////////////////

    // Enable bit in RXCFG and TXCFG
    localparam int CFG_EN_BIT = 4;

    localparam int STATUS_RX_BUSY_BIT = 0;
    localparam int STATUS_TX_BUSY_BIT = 1;

endpackage

// File: logic/udma_cfg_regs.sv
`timescale 1ns/1ps
/*
 * uDMA channel register bank
 * Decodes the cfg strobe bus and issues one-cycle start pulses to the streamers
 */
module udma_cfg_regs #(
    parameter int L2_AW  = 12,
    parameter int SIZE_W = 16
) (
    input  logic                        sys_clk,
    input  logic                        rst_n,
    input  logic                        cfg_valid_i,
    input  logic                        cfg_rwn_i,
    input  logic [udma_pkg::CFG_AW-1:0] cfg_addr_i,
    input  logic [udma_pkg::CFG_DW-1:0] cfg_data_i,
    input  logic                        tx_busy_i,
    input  logic                        rx_busy_i,
    input  logic [SIZE_W-1:0]           tx_bytes_left_i,
    input  logic [SIZE_W-1:0]           rx_bytes_left_i,
    output logic [udma_pkg::CFG_DW-1:0] cfg_data_o,
    output logic                        tx_start_o,
    output logic [L2_AW-1:0]            tx_saddr_o,
    output logic [SIZE_W-1:0]           tx_size_o,
    output logic                        rx_start_o,
    output logic [L2_AW-1:0]            rx_saddr_o,
    output logic [SIZE_W-1:0]           rx_size_o
);

    udma_pkg::cfg_reg_e reg_sel;
    logic               cfg_wr;
    logic               tx_en_q;
    logic               rx_en_q;
    logic               tx_kick;
    logic               rx_kick;

    assign reg_sel = udma_pkg::cfg_reg_e'(cfg_addr_i);
    assign cfg_wr  = cfg_valid_i && !cfg_rwn_i;

    // Enable write with a valid size to an idle streamer
    assign tx_kick = cfg_wr && (reg_sel == udma_pkg::TXCFG)
                     && cfg_data_i[udma_pkg::CFG_EN_BIT]
                     && (tx_size_o != '0) && !tx_busy_i && !tx_start_o;
    assign rx_kick = cfg_wr && (reg_sel == udma_pkg::RXCFG)
                     && cfg_data_i[udma_pkg::CFG_EN_BIT]
                     && (rx_size_o != '0) && !rx_busy_i && !rx_start_o;

    //////////////////////////////////////////////////
    // Register writes and start pulses
    //////////////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_saddr_o <= '0;
            rx_size_o  <= '0;
            rx_en_q    <= 1'b0;
            tx_saddr_o <= '0;
            tx_size_o  <= '0;
            tx_en_q    <= 1'b0;
            tx_start_o <= 1'b0;
            rx_start_o <= 1'b0;
        end else begin
            tx_start_o <= tx_kick;  // One cycle only
            rx_start_o <= rx_kick;
            if (cfg_wr) begin
                case (reg_sel)
                    udma_pkg::RX_SADDR: rx_saddr_o <= cfg_data_i[L2_AW-1:0];
                    udma_pkg::RX_SIZE:  rx_size_o  <= cfg_data_i[SIZE_W-1:0];
                    udma_pkg::RXCFG:    rx_en_q    <= cfg_data_i[udma_pkg::CFG_EN_BIT];
                    udma_pkg::TX_SADDR: tx_saddr_o <= cfg_data_i[L2_AW-1:0];
                    udma_pkg::TX_SIZE:  tx_size_o  <= cfg_data_i[SIZE_W-1:0];
                    udma_pkg::TXCFG:    tx_en_q    <= cfg_data_i[udma_pkg::CFG_EN_BIT];
                    default: ;                      // STATUS is read only
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////

    always_comb begin
        cfg_data_o = '0;  // Unknown addresses read as zero
        case (reg_sel)
            udma_pkg::RX_SADDR: cfg_data_o[L2_AW-1:0]  = rx_saddr_o;
            udma_pkg::RX_SIZE:  cfg_data_o[SIZE_W-1:0] = rx_bytes_left_i;
            udma_pkg::RXCFG:    cfg_data_o[udma_pkg::CFG_EN_BIT] = rx_en_q;
            udma_pkg::TX_SADDR: cfg_data_o[L2_AW-1:0]  = tx_saddr_o;
            udma_pkg::TX_SIZE:  cfg_data_o[SIZE_W-1:0] = tx_bytes_left_i;
            udma_pkg::TXCFG:    cfg_data_o[udma_pkg::CFG_EN_BIT] = tx_en_q;
            udma_pkg::STATUS: begin
                cfg_data_o[udma_pkg::STATUS_RX_BUSY_BIT] = rx_busy_i;
                cfg_data_o[udma_pkg::STATUS_TX_BUSY_BIT] = tx_busy_i;
            end
            default: ;
        endcase
    end

    // A running stream is never restarted
    a_tx_start_idle: assert property (
        @(posedge sys_clk) disable iff (!rst_n) tx_start_o |-> !tx_busy_i
    );
    a_rx_start_idle: assert property (
        @(posedge sys_clk) disable iff (!rst_n) rx_start_o |-> !rx_busy_i
    );

endmodule

// File: logic/l2_byte_mem.sv
`timescale 1ns/1ps
/*
 * L2 byte memory
 * One word write port and one combinational word read port, little-endian
 */
module l2_byte_mem #(
    parameter int L2_AW = 12
) (
    input  logic                              sys_clk,
    input  logic                              wr_en_i,
    input  logic [L2_AW-1:0]                  wr_addr_i,
    input  logic [udma_pkg::WORD_BYTES*8-1:0] wr_data_i,
    input  logic [L2_AW-1:0]                  rd_addr_i,
    output logic [udma_pkg::WORD_BYTES*8-1:0] rd_data_o
);

    localparam int DEPTH = 1 << L2_AW;

    logic [7:0] mem [DEPTH];

    // Byte 0 of the word lands at the base address
    always_ff @(posedge sys_clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < udma_pkg::WORD_BYTES; b++) begin
                mem[wr_addr_i + L2_AW'(b)] <= wr_data_i[8*b +: 8];
            end
        end
    end

    always_comb begin
        for (int b = 0; b < udma_pkg::WORD_BYTES; b++) begin
            rd_data_o[8*b +: 8] = mem[rd_addr_i + L2_AW'(b)];  // Low byte first
        end
    end

    // RX writes never run past the top of L2
    a_wr_in_range: assert property (
        @(posedge sys_clk) wr_en_i |->
            ({1'b0, wr_addr_i} + udma_pkg::WORD_BYTES - 1) < DEPTH
    );

endmodule

// File: logic/tx_stream.sv
`timescale 1ns/1ps
/*
 * TX streamer
 * Reads words from L2 starting at a programmed address and offers them
 * under valid/ready until the byte count reaches zero
 */
module tx_stream #(
    parameter int L2_AW  = 12,
    parameter int SIZE_W = 16
) (
    input  logic                              sys_clk,
    input  logic                              rst_n,
    input  logic                              start_i,
    input  logic [L2_AW-1:0]                  saddr_i,
    input  logic [SIZE_W-1:0]                 size_i,
    input  logic                              tx_ready_i,
    input  logic [udma_pkg::WORD_BYTES*8-1:0] mem_rdata_i,
    output logic [L2_AW-1:0]                  mem_raddr_o,
    output logic                              tx_valid_o,
    output logic [udma_pkg::WORD_BYTES*8-1:0] tx_data_o,
    output logic                              busy_o,
    output logic [SIZE_W-1:0]                 bytes_left_o,
    output logic                              eot_o
);

    typedef enum logic {
        TX_IDLE,
        TX_BUSY
    } tx_state_e;

    tx_state_e         state_q;
    logic [L2_AW-1:0]  addr_q;
    logic [SIZE_W-1:0] bytes_left_q;
    logic              eot_q;
    logic              beat;
    logic              last_beat;

    assign beat      = (state_q == TX_BUSY) && tx_ready_i;
    assign last_beat = bytes_left_q <= SIZE_W'(udma_pkg::WORD_BYTES);  // Saturates at zero

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= TX_IDLE;
            addr_q       <= '0;
            bytes_left_q <= '0;
            eot_q        <= 1'b0;
        end else begin
            eot_q <= 1'b0;
            if (start_i) begin
                state_q      <= TX_BUSY;
                addr_q       <= saddr_i;
                bytes_left_q <= size_i;
            end else if (beat) begin
                addr_q <= addr_q + L2_AW'(udma_pkg::WORD_BYTES);
                if (last_beat) begin
                    bytes_left_q <= '0;
                    state_q      <= TX_IDLE;
                    eot_q        <= 1'b1;  // Pulses as busy drops
                end else begin
                    bytes_left_q <= bytes_left_q - SIZE_W'(udma_pkg::WORD_BYTES);
                end
            end
        end
    end

    // Word at the running address, held until accepted
    assign mem_raddr_o  = addr_q;
    assign tx_data_o    = mem_rdata_i;
    assign tx_valid_o   = (state_q == TX_BUSY);
    assign busy_o       = (state_q == TX_BUSY);
    assign bytes_left_o = bytes_left_q;
    assign eot_o        = eot_q;

    // Back-pressure holds the offered word
    a_tx_hold: assert property (
        @(posedge sys_clk) disable iff (!rst_n)
            (tx_valid_o && !tx_ready_i) |=> (tx_valid_o && $stable(tx_data_o))
    );

endmodule

// File: logic/rx_stream.sv
`timescale 1ns/1ps
/*
 * RX streamer
 * Accepts words under valid/ready and writes them to L2 at a running address
 */
module rx_stream #(
    parameter int L2_AW  = 12,
    parameter int SIZE_W = 16
) (
    input  logic                              sys_clk,
    input  logic                              rst_n,
    input  logic                              start_i,
    input  logic [L2_AW-1:0]                  saddr_i,
    input  logic [SIZE_W-1:0]                 size_i,
    input  logic                              rx_valid_i,
    input  logic [udma_pkg::WORD_BYTES*8-1:0] rx_data_i,
    output logic                              rx_ready_o,
    output logic                              mem_we_o,
    output logic [L2_AW-1:0]                  mem_waddr_o,
    output logic [udma_pkg::WORD_BYTES*8-1:0] mem_wdata_o,
    output logic                              busy_o,
    output logic [SIZE_W-1:0]                 bytes_left_o,
    output logic                              eot_o
);

    typedef enum logic {
        RX_IDLE,
        RX_BUSY
    } rx_state_e;

    rx_state_e         state_q;
    logic [L2_AW-1:0]  addr_q;
    logic [SIZE_W-1:0] bytes_left_q;
    logic              eot_q;
    logic              beat;
    logic              last_beat;

    assign beat      = (state_q == RX_BUSY) && rx_valid_i;  // Idle traffic is dropped
    assign last_beat = bytes_left_q <= SIZE_W'(udma_pkg::WORD_BYTES);

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= RX_IDLE;
            addr_q       <= '0;
            bytes_left_q <= '0;
            eot_q        <= 1'b0;
        end else begin
            eot_q <= 1'b0;
            if (start_i) begin
                state_q      <= RX_BUSY;
                addr_q       <= saddr_i;
                bytes_left_q <= size_i;
            end else if (beat) begin
                addr_q <= addr_q + L2_AW'(udma_pkg::WORD_BYTES);
                if (last_beat) begin
                    bytes_left_q <= '0;
                    state_q      <= RX_IDLE;
                    eot_q        <= 1'b1;
                end else begin
                    bytes_left_q <= bytes_left_q - SIZE_W'(udma_pkg::WORD_BYTES);
                end
            end
        end
    end

    assign rx_ready_o   = (state_q == RX_BUSY);
    assign mem_we_o     = beat;       // Written at the accepting edge
    assign mem_waddr_o  = addr_q;
    assign mem_wdata_o  = rx_data_i;
    assign busy_o       = (state_q == RX_BUSY);
    assign bytes_left_o = bytes_left_q;
    assign eot_o        = eot_q;

    // Every L2 write belongs to a stream with bytes still owed
    a_rx_we_busy: assert property (
        @(posedge sys_clk) disable iff (!rst_n)
            mem_we_o |-> (busy_o && bytes_left_o != '0)
    );

endmodule

// File: logic/udma_l2_channel.sv
`timescale 1ns/1ps
/*
 * uDMA L2 channel top level
 * Register bank, L2 memory and the TX and RX streamers
 */
module udma_l2_channel #(
    parameter int L2_AW  = 12,
    parameter int SIZE_W = 16
) (
    input  logic                              sys_clk,
    input  logic                              rst_n,
    input  logic                              cfg_valid_i,
    input  logic                              cfg_rwn_i,
    input  logic [udma_pkg::CFG_AW-1:0]       cfg_addr_i,
    input  logic [udma_pkg::CFG_DW-1:0]       cfg_data_i,
    output logic [udma_pkg::CFG_DW-1:0]       cfg_data_o,
    output logic                              tx_valid_o,
    output logic [udma_pkg::WORD_BYTES*8-1:0] tx_data_o,
    input  logic                              tx_ready_i,
    input  logic                              rx_valid_i,
    input  logic [udma_pkg::WORD_BYTES*8-1:0] rx_data_i,
    output logic                              rx_ready_o,
    output logic                              tx_eot_o,
    output logic                              rx_eot_o
);

    logic                              tx_start;
    logic [L2_AW-1:0]                  tx_saddr;
    logic [SIZE_W-1:0]                 tx_size;
    logic                              tx_busy;
    logic [SIZE_W-1:0]                 tx_bytes_left;
    logic                              rx_start;
    logic [L2_AW-1:0]                  rx_saddr;
    logic [SIZE_W-1:0]                 rx_size;
    logic                              rx_busy;
    logic [SIZE_W-1:0]                 rx_bytes_left;
    logic                              mem_we;
    logic [L2_AW-1:0]                  mem_waddr;
    logic [udma_pkg::WORD_BYTES*8-1:0] mem_wdata;
    logic [L2_AW-1:0]                  mem_raddr;
    logic [udma_pkg::WORD_BYTES*8-1:0] mem_rdata;

    udma_cfg_regs #(
        .L2_AW  (L2_AW),
        .SIZE_W (SIZE_W)
    ) i_cfg_regs (
        .sys_clk         (sys_clk),
        .rst_n           (rst_n),
        .cfg_valid_i     (cfg_valid_i),
        .cfg_rwn_i       (cfg_rwn_i),
        .cfg_addr_i      (cfg_addr_i),
        .cfg_data_i      (cfg_data_i),
        .tx_busy_i       (tx_busy),
        .rx_busy_i       (rx_busy),
        .tx_bytes_left_i (tx_bytes_left),
        .rx_bytes_left_i (rx_bytes_left),
        .cfg_data_o      (cfg_data_o),
        .tx_start_o      (tx_start),
        .tx_saddr_o      (tx_saddr),
        .tx_size_o       (tx_size),
        .rx_start_o      (rx_start),
        .rx_saddr_o      (rx_saddr),
        .rx_size_o       (rx_size)
    );

    l2_byte_mem #(
        .L2_AW (L2_AW)
    ) i_l2_mem (
        .sys_clk   (sys_clk),
        .wr_en_i   (mem_we),
        .wr_addr_i (mem_waddr),
        .wr_data_i (mem_wdata),
        .rd_addr_i (mem_raddr),
        .rd_data_o (mem_rdata)
    );

    tx_stream #(
        .L2_AW  (L2_AW),
        .SIZE_W (SIZE_W)
    ) i_tx_stream (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .start_i      (tx_start),
        .saddr_i      (tx_saddr),
        .size_i       (tx_size),
        .tx_ready_i   (tx_ready_i),
        .mem_rdata_i  (mem_rdata),
        .mem_raddr_o  (mem_raddr),
        .tx_valid_o   (tx_valid_o),
        .tx_data_o    (tx_data_o),
        .busy_o       (tx_busy),
        .bytes_left_o (tx_bytes_left),
        .eot_o        (tx_eot_o)
    );

    rx_stream #(
        .L2_AW  (L2_AW),
        .SIZE_W (SIZE_W)
    ) i_rx_stream (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .start_i      (rx_start),
        .saddr_i      (rx_saddr),
        .size_i       (rx_size),
        .rx_valid_i   (rx_valid_i),
        .rx_data_i    (rx_data_i),
        .rx_ready_o   (rx_ready_o),
        .mem_we_o     (mem_we),
        .mem_waddr_o  (mem_waddr),
        .mem_wdata_o  (mem_wdata),
        .busy_o       (rx_busy),
        .bytes_left_o (rx_bytes_left),
        .eot_o        (rx_eot_o)
    );

endmodule

// File: verification/tb_udma_l2_channel.sv
`timescale 1ns/1ps
/*
 * Testbench for the uDMA L2 channel
 * Fills L2 through RX, streams it back through TX, then checks back-pressure and restarts
 */
module tb_udma_l2_channel;

    localparam int L2_AW     = 12;
    localparam int SIZE_W    = 16;
    localparam int DEPTH     = 1 << L2_AW;
    localparam int N_WORDS   = 3;
    localparam int XFER_SIZE = 10;
    localparam int WAIT_MAX  = 200;  // Cycles allowed for any one wait

    logic                        sys_clk;
    logic                        rst_n;
    logic                        cfg_valid_i;
    logic                        cfg_rwn_i;
    logic [udma_pkg::CFG_AW-1:0] cfg_addr_i;
    logic [udma_pkg::CFG_DW-1:0] cfg_data_i;
    logic [udma_pkg::CFG_DW-1:0] cfg_data_o;
    logic                        tx_valid_o;
    logic [31:0]                 tx_data_o;
    logic                        tx_ready_i;
    logic                        rx_valid_i;
    logic [31:0]                 rx_data_i;
    logic                        rx_ready_o;
    logic                        tx_eot_o;
    logic                        rx_eot_o;

    int                          error_count;
    int                          check_count;
    logic [31:0]                 rng;
    logic [31:0]                 exp_words [N_WORDS];  // Words written to L2 through RX
    logic [L2_AW-1:0]            base_addr;
    logic [31:0]                 held_data;

    udma_l2_channel #(
        .L2_AW  (L2_AW),
        .SIZE_W (SIZE_W)
    ) i_dut (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .cfg_valid_i (cfg_valid_i),
        .cfg_rwn_i   (cfg_rwn_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_data_i  (cfg_data_i),
        .cfg_data_o  (cfg_data_o),
        .tx_valid_o  (tx_valid_o),
        .tx_data_o   (tx_data_o),
        .tx_ready_i  (tx_ready_i),
        .rx_valid_i  (rx_valid_i),
        .rx_data_i   (rx_data_i),
        .rx_ready_o  (rx_ready_o),
        .tx_eot_o    (tx_eot_o),
        .rx_eot_o    (rx_eot_o)
    );

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;  // 100 ns period
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Bytes still owed after some 4-byte words, never below zero
    function automatic int bytes_owed(input int size, input int words);
        int left;
        left = size - 4 * words;
        return (left > 0) ? left : 0;
    endfunction

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        error_count++;
        $display("** Error at %0d ns: %s expected 0x%08h, got 0x%08h",
                 $time, name, expected, actual);
    endtask

    task automatic report_fault(input string what);
        error_count++;
        $display("Error at %0d ns: %s", $time, what);
    endtask

    task automatic expect_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        check_count++;
        assert (actual == expected) else report_value(name, expected, actual);
    endtask

    //////////////////////////////////////////////////
    // cfg bus, one strobe per access
    //////////////////////////////////////////////////

    task automatic cfg_write(input udma_pkg::cfg_reg_e addr, input logic [31:0] data);
        @(negedge sys_clk);
        cfg_valid_i = 1'b1;
        cfg_rwn_i   = 1'b0;
        cfg_addr_i  = addr;
        cfg_data_i  = data;
        @(negedge sys_clk);
        cfg_valid_i = 1'b0;
    endtask

    task automatic cfg_read(input udma_pkg::cfg_reg_e addr, output logic [31:0] data);
        @(negedge sys_clk);
        cfg_valid_i = 1'b1;
        cfg_rwn_i   = 1'b1;
        cfg_addr_i  = addr;
        #10 data = cfg_data_o;  // Combinational read data
        @(negedge sys_clk);
        cfg_valid_i = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Streams
    //////////////////////////////////////////////////

    // Offers words with random gaps and reads RX_SIZE in every cycle
    task automatic run_rx();
        int taken;
        int eots;
        int cycles;
        taken  = 0;
        eots   = 0;
        cycles = 0;
        while (eots == 0 && cycles < WAIT_MAX) begin
            @(negedge sys_clk);
            cycles++;
            rx_valid_i  = rng[0] | rng[1];
            rx_data_i   = exp_words[(taken < N_WORDS) ? taken : N_WORDS - 1];
            cfg_valid_i = 1'b1;
            cfg_rwn_i   = 1'b1;
            cfg_addr_i  = udma_pkg::RX_SIZE;
            rng         = xorshift(rng);
            #10;
            if (rx_eot_o) eots++;
            if (rx_ready_o) begin
                expect_value("RX_SIZE", 32'(bytes_owed(XFER_SIZE, taken)), cfg_data_o);
                if (rx_valid_i) taken++;
            end
        end
        if (eots == 0) report_fault("timeout, rx_eot_o never pulsed");
        repeat (4) begin
            @(negedge sys_clk);
            cfg_valid_i = 1'b0;
            rx_valid_i  = 1'b1;  // Extra words must be ignored
            #10;
            if (rx_ready_o) taken++;
            if (rx_eot_o) eots++;
        end
        @(negedge sys_clk);
        rx_valid_i = 1'b0;
        expect_value("RX words accepted", 32'(N_WORDS), 32'(taken));
        expect_value("rx_eot_o pulses", 32'd1, 32'(eots));
    endtask

    // Takes words from index first on, with optional random back-pressure
    task automatic run_tx(input bit throttle, input int first, output int words);
        int eots;
        int cycles;
        words  = first;
        eots   = 0;
        cycles = 0;
        while (eots == 0 && cycles < WAIT_MAX) begin
            @(negedge sys_clk);
            cycles++;
            tx_ready_i = throttle ? (rng[3] & rng[4]) : 1'b1;
            rng        = xorshift(rng);
            #10;
            if (tx_eot_o) eots++;
            if (tx_valid_o && tx_ready_i) begin
                if (words < N_WORDS) expect_value("tx_data_o", exp_words[words], tx_data_o);
                words++;
            end
        end
        if (eots == 0) report_fault("timeout, tx_eot_o never pulsed");
        repeat (4) begin
            @(negedge sys_clk);
            tx_ready_i = 1'b1;
            #10;
            if (tx_valid_o) words++;  // Word beyond the end
            if (tx_eot_o) eots++;
        end
        expect_value("tx_eot_o pulses", 32'd1, 32'(eots));
    endtask

    task automatic wait_tx_valid();
        int cycles;
        cycles = 0;
        while (!tx_valid_o && cycles < WAIT_MAX) begin
            @(negedge sys_clk);
            cycles++;
        end
        if (!tx_valid_o) report_fault("timeout, tx_valid_o never rose");
    endtask

    //////////////////////////////////////////////////
    // Concurrent checks
    //////////////////////////////////////////////////

    always @(posedge sys_clk) held_data <= tx_data_o;

    a_tx_data_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (tx_valid_o && !tx_ready_i) |=> (tx_data_o == held_data))
        else report_value("tx_data_o", $sampled(held_data), $sampled(tx_data_o));
    a_tx_valid_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (tx_valid_o && !tx_ready_i) |=> tx_valid_o)
        else report_fault("tx_valid_o dropped before its word was taken");
    a_tx_eot: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $fell(tx_valid_o) == tx_eot_o)
        else report_fault("tx_eot_o and the fall of tx_valid_o did not coincide");
    a_rx_eot: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $fell(rx_ready_o) == rx_eot_o)
        else report_fault("rx_eot_o and the fall of rx_ready_o did not coincide");

    initial begin
        logic [31:0] rd;
        int          words;
        rng         = 32'd32;  // Seed
        error_count = 0;
        check_count = 0;
        rst_n       = 1'b0;
        cfg_valid_i = 1'b0;
        cfg_rwn_i   = 1'b1;
        cfg_addr_i  = '0;
        cfg_data_i  = '0;
        tx_ready_i  = 1'b0;
        rx_valid_i  = 1'b0;
        rx_data_i   = '0;
        repeat (3) @(negedge sys_clk);
        rst_n = 1'b1;

        // Reset state
        expect_value("tx_valid_o", 32'd0, 32'(tx_valid_o));
        expect_value("rx_ready_o", 32'd0, 32'(rx_ready_o));
        expect_value("tx_eot_o", 32'd0, 32'(tx_eot_o));
        expect_value("rx_eot_o", 32'd0, 32'(rx_eot_o));
        cfg_read(udma_pkg::STATUS, rd);
        expect_value("STATUS", 32'd0, rd);

        // Start address readback
        rng = xorshift(rng);
        cfg_write(udma_pkg::TX_SADDR, rng);
        cfg_read(udma_pkg::TX_SADDR, rd);
        expect_value("TX_SADDR", rng & 32'(DEPTH - 1), rd);
        rng = xorshift(rng);
        cfg_write(udma_pkg::RX_SADDR, rng);
        cfg_read(udma_pkg::RX_SADDR, rd);
        expect_value("RX_SADDR", rng & 32'(DEPTH - 1), rd);

        // RX fill at an aligned address clear of the top of L2
        rng       = xorshift(rng);
        base_addr = L2_AW'((rng % 32'(DEPTH - 16)) & ~32'h3);
        for (int i = 0; i < N_WORDS; i++) begin
            rng          = xorshift(rng);
            exp_words[i] = rng;
        end
        cfg_write(udma_pkg::RX_SADDR, 32'(base_addr));
        cfg_write(udma_pkg::RX_SIZE, 32'(XFER_SIZE));
        cfg_write(udma_pkg::RXCFG, 32'd1 << udma_pkg::CFG_EN_BIT);
        run_rx();

        // TX readback, then the same stream under back-pressure
        cfg_write(udma_pkg::TX_SADDR, 32'(base_addr));
        cfg_write(udma_pkg::TX_SIZE, 32'(XFER_SIZE));
        cfg_write(udma_pkg::TXCFG, 32'd1 << udma_pkg::CFG_EN_BIT);
        run_tx(1'b0, 0, words);
        expect_value("TX words", 32'(N_WORDS), 32'(words));
        cfg_write(udma_pkg::TXCFG, 32'd1 << udma_pkg::CFG_EN_BIT);
        run_tx(1'b1, 0, words);
        expect_value("TX words with back-pressure", 32'(N_WORDS), 32'(words));

        // Zero size never starts
        cfg_write(udma_pkg::TX_SIZE, 32'd0);
        cfg_write(udma_pkg::TXCFG, 32'd1 << udma_pkg::CFG_EN_BIT);
        repeat (8) begin
            @(negedge sys_clk);
            check_count++;
            assert (!tx_valid_o) else report_fault("tx_valid_o rose for a zero-size transfer");
        end

        // Enable while busy, after the first word has gone
        cfg_write(udma_pkg::TX_SIZE, 32'(XFER_SIZE));
        tx_ready_i = 1'b0;
        cfg_write(udma_pkg::TXCFG, 32'd1 << udma_pkg::CFG_EN_BIT);
        wait_tx_valid();
        tx_ready_i = 1'b1;
        #10 expect_value("tx_data_o", exp_words[0], tx_data_o);
        @(negedge sys_clk);
        tx_ready_i = 1'b0;
        cfg_read(udma_pkg::STATUS, rd);  // Only TX is busy here
        expect_value("STATUS", 32'd1 << udma_pkg::STATUS_TX_BUSY_BIT, rd);
        cfg_read(udma_pkg::TXCFG, rd);
        expect_value("TXCFG", 32'd1 << udma_pkg::CFG_EN_BIT, rd);
        cfg_write(udma_pkg::TXCFG, 32'd1 << udma_pkg::CFG_EN_BIT);
        run_tx(1'b0, 1, words);
        expect_value("TX words across a busy enable", 32'(N_WORDS), 32'(words));

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
logic/udma_pkg.sv
logic/udma_cfg_regs.sv
logic/l2_byte_mem.sv
logic/tx_stream.sv
logic/rx_stream.sv
logic/udma_l2_channel.sv
verification/tb_udma_l2_channel.sv

// File: Makefile
# Verilator flow for the uDMA L2 channel testbench

VERILATOR ?= verilator
TOP       ?= tb_udma_l2_channel
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
